// ==== aes_pkg.sv ====
package aes_pkg;

   // ==========================================================
   // Sizes and types
   // ==========================================================
   localparam int NUM_ROUND_KEYS = 15;     // Whitening key plus up to 14 round keys.
   localparam int MAX_ROUNDS     = 14;     // Round count for a 256-bit key.

   // Key-size code. Code 2'b11 has no name and decodes as a 256-bit key.
   typedef enum logic [1:0] {
      KEY_128 = 2'b00,
      KEY_192 = 2'b01,
      KEY_256 = 2'b10
   } key_size_e;

   typedef logic [7:0] byte_t;
   // Byte 15 is the first byte of the block and the bytes run down each column.
   typedef byte_t [15:0] block_t;
   typedef byte_t [15:0] round_key_t;      // Same byte layout as the state.
   typedef round_key_t [NUM_ROUND_KEYS-1:0] key_sched_t;   // Index 0 is the first key.
   typedef logic [3:0] round_idx_t;        // Round-key index from 0 to 14.

   // ==========================================================
   // Substitution tables
   // ==========================================================
   // Each line holds sixteen entries, so entry 0 is the leftmost byte.
   localparam logic [0:255][7:0] SBOX = {
      128'h637c777b_f26b6fc5_3001672b_fed7ab76, 128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
      128'hb7fd9326_363ff7cc_34a5e5f1_71d83115, 128'h04c723c3_1896059a_071280e2_eb27b275,
      128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84, 128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
      128'hd0efaafb_434d3385_45f9027f_503c9fa8, 128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
      128'hcd0c13ec_5f974417_c4a77e3d_645d1973, 128'h60814fdc_222a9088_46eeb814_de5e0bdb,
      128'he0323a0a_4906245c_c2d3ac62_9195e479, 128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
      128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a, 128'h703eb566_4803f60e_613557b9_86c11d9e,
      128'he1f89811_69d98e94_9b1e87e9_ce5528df, 128'h8ca1890d_bfe64268_41992d0f_b054bb16
   };

   // Inverse table, in the same layout as the forward one.
   localparam logic [0:255][7:0] INV_SBOX = {
      128'h52096ad5_3036a538_bf40a39e_81f3d7fb, 128'h7ce33982_9b2fff87_348e4344_c4dee9cb,
      128'h547b9432_a6c2233d_ee4c950b_42fac34e, 128'h082ea166_28d924b2_765ba249_6d8bd125,
      128'h72f8f664_86689816_d4a45ccc_5d65b692, 128'h6c704850_fdedb9da_5e154657_a78d9d84,
      128'h90d8ab00_8cbcd30a_f7e45805_b8b34506, 128'hd02c1e8f_ca3f0f02_c1afbd03_01138a6b,
      128'h3a911141_4f67dcea_97f2cfce_f0b4e673, 128'h96ac7422_e7ad3585_e2f937e8_1c75df6e,
      128'h47f11a71_1d29c589_6fb7620e_aa18be1b, 128'hfc563e4b_c6d27920_9adbc0fe_78cd5af4,
      128'h1fdda833_8807c731_b1121059_2780ec5f, 128'h60517fa9_19b54a0d_2de57a9f_93c99cef,
      128'ha0e03b4d_ae2af5b0_c8ebbb3c_83539961, 128'h172b047e_ba77d626_e1691463_55210c7d
   };

   // ==========================================================
   // GF(2^8) constant multiplies
   // ==========================================================
   // Doubling shifts left and folds the carry back in with the 8'h1b polynomial.
   function automatic byte_t gf_x2(input byte_t x);
      return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
   endfunction

   function automatic byte_t gf_x3(input byte_t x);
      return gf_x2(x) ^ x;                 // 3x is 2x plus x.
   endfunction

   // The inverse multiplies are built from x, 2x, 4x and 8x.
   function automatic byte_t gf_x9(input byte_t x);
      return gf_x2(gf_x2(gf_x2(x))) ^ x;   // 8x plus x.
   endfunction

   function automatic byte_t gf_xb(input byte_t x);
      byte_t x2;
      x2 = gf_x2(x);
      return gf_x2(gf_x2(x2)) ^ x2 ^ x;    // 8x plus 2x plus x.
   endfunction

   function automatic byte_t gf_xd(input byte_t x);
      byte_t x4;
      x4 = gf_x2(gf_x2(x));
      return gf_x2(x4) ^ x4 ^ x;           // 8x plus 4x plus x.
   endfunction

   function automatic byte_t gf_xe(input byte_t x);
      byte_t x2;
      byte_t x4;
      x2 = gf_x2(x);
      x4 = gf_x2(x2);
      return gf_x2(x4) ^ x4 ^ x2;          // 8x plus 4x plus 2x.
   endfunction

   // Round count for a key size. Both 2'b10 and 2'b11 give 14 rounds.
   function automatic round_idx_t num_rounds(input key_size_e key_size);
      case (key_size)
         KEY_128: return 4'd10;
         KEY_192: return 4'd12;
         default: return round_idx_t'(MAX_ROUNDS);
      endcase
   endfunction

endpackage

// ==== aes_round_ctrl.sv ====
`timescale 1ns/100ps

// Round sequencer for one cipher direction.
module aes_round_ctrl #(
   parameter bit DECRYPT = 1'b0
) (
   input  logic                eph1,
   input  logic                rst,
   input  logic                start,
   input  aes_pkg::key_size_e  key_size,
   input  aes_pkg::key_sched_t key_words,
   output logic                first,
   output logic                last,
   output logic                busy,
   output aes_pkg::round_key_t round_key,
   output aes_pkg::round_key_t init_key
);

   typedef enum logic {
      IDLE,
      RUN
   } state_e;

   state_e              state;
   aes_pkg::round_idx_t round_cnt;         // Round being computed, 1 to Nr while running.
   aes_pkg::round_idx_t num_rnd;           // Nr for the current key size.
   aes_pkg::round_idx_t key_idx;

   assign num_rnd = aes_pkg::num_rounds(key_size);

   // ==========================================================
   // FSM and round counter
   // ==========================================================
   always_ff @(posedge eph1) begin
      if (rst) begin
         state     <= IDLE;
         round_cnt <= '0;
      end else if (start) begin           // A new start always wins, even mid-run.
         state     <= RUN;
         round_cnt <= 4'd1;
      end else if (state == RUN) begin
         if (round_cnt == num_rnd) begin  // Final round is being written this edge.
            state     <= IDLE;
            round_cnt <= '0;
         end else begin
            round_cnt <= round_cnt + 4'd1;
         end
      end
   end

   assign first = start;                   // Whitening happens on the start edge.
   assign busy  = (state == RUN);
   // A restart on the final round drops the old block, so no done follows it.
   assign last  = busy && (round_cnt == num_rnd) && !start;

   // ==========================================================
   // Round-key select
   // ==========================================================
   // Encryption walks keys 1 to Nr. Decryption walks Nr-1 down to 0.
   assign key_idx   = DECRYPT ? (num_rnd - round_cnt) : round_cnt;
   assign round_key = key_words[key_idx];
   assign init_key  = DECRYPT ? key_words[num_rnd] : key_words[0];   // Whitening key.

endmodule

// ==== aes_enc_round.sv ====
`timescale 1ns/100ps

// One forward AES round, purely combinational.
module aes_enc_round (
   input  aes_pkg::block_t     state_in,
   input  aes_pkg::round_key_t round_key,
   input  logic                last,
   output aes_pkg::block_t     state_out
);

   aes_pkg::block_t sub_bytes;
   aes_pkg::block_t shift_rows;
   aes_pkg::block_t mix_cols;

   // SubBytes looks every byte up in the forward table.
   always_comb begin
      for (int i = 0; i < 16; i++) begin
         sub_bytes[i] = aes_pkg::SBOX[state_in[i]];
      end
   end

   // ShiftRows rotates row r left by r columns.
   // Byte (row r, column c) sits at index 15 - 4c - r.
   always_comb begin
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            shift_rows[15 - 4*c - r] = sub_bytes[15 - 4*((c + r) % 4) - r];
         end
      end
   end

   // MixColumns multiplies each column by the circulant matrix {2 3 1 1}.
   always_comb begin
      aes_pkg::byte_t a0;
      aes_pkg::byte_t a1;
      aes_pkg::byte_t a2;
      aes_pkg::byte_t a3;
      for (int c = 0; c < 4; c++) begin
         a0 = shift_rows[15 - 4*c];        // Top of the column.
         a1 = shift_rows[14 - 4*c];
         a2 = shift_rows[13 - 4*c];
         a3 = shift_rows[12 - 4*c];
         mix_cols[15 - 4*c] = aes_pkg::gf_x2(a0) ^ aes_pkg::gf_x3(a1) ^ a2 ^ a3;
         mix_cols[14 - 4*c] = a0 ^ aes_pkg::gf_x2(a1) ^ aes_pkg::gf_x3(a2) ^ a3;
         mix_cols[13 - 4*c] = a0 ^ a1 ^ aes_pkg::gf_x2(a2) ^ aes_pkg::gf_x3(a3);
         mix_cols[12 - 4*c] = aes_pkg::gf_x3(a0) ^ a1 ^ a2 ^ aes_pkg::gf_x2(a3);
      end
   end

   // The final round leaves MixColumns out, then AddRoundKey closes the round.
   assign state_out = (last ? shift_rows : mix_cols) ^ round_key;

endmodule

// ==== aes_dec_round.sv ====
`timescale 1ns/100ps

// One inverse AES round, purely combinational.
module aes_dec_round (
   input  aes_pkg::block_t     state_in,
   input  aes_pkg::round_key_t round_key,
   input  logic                last,
   output aes_pkg::block_t     state_out
);

   aes_pkg::block_t inv_shift;
   aes_pkg::block_t inv_sub;
   aes_pkg::block_t add_key;
   aes_pkg::block_t inv_mix;

   // InvShiftRows rotates row r right by r columns.
   always_comb begin
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            inv_shift[15 - 4*c - r] = state_in[15 - 4*((c - r + 4) % 4) - r];
         end
      end
   end

   // InvSubBytes uses the inverse table on each byte.
   always_comb begin
      for (int i = 0; i < 16; i++) begin
         inv_sub[i] = aes_pkg::INV_SBOX[inv_shift[i]];
      end
   end

   assign add_key = inv_sub ^ round_key;   // AddRoundKey comes before InvMixColumns.

   // InvMixColumns multiplies each column by the circulant matrix {e b d 9}.
   always_comb begin
      aes_pkg::byte_t a0;
      aes_pkg::byte_t a1;
      aes_pkg::byte_t a2;
      aes_pkg::byte_t a3;
      for (int c = 0; c < 4; c++) begin
         a0 = add_key[15 - 4*c];
         a1 = add_key[14 - 4*c];
         a2 = add_key[13 - 4*c];
         a3 = add_key[12 - 4*c];           // Bottom of the column.
         inv_mix[15 - 4*c] = aes_pkg::gf_xe(a0) ^ aes_pkg::gf_xb(a1) ^
                             aes_pkg::gf_xd(a2) ^ aes_pkg::gf_x9(a3);
         inv_mix[14 - 4*c] = aes_pkg::gf_x9(a0) ^ aes_pkg::gf_xe(a1) ^
                             aes_pkg::gf_xb(a2) ^ aes_pkg::gf_xd(a3);
         inv_mix[13 - 4*c] = aes_pkg::gf_xd(a0) ^ aes_pkg::gf_x9(a1) ^
                             aes_pkg::gf_xe(a2) ^ aes_pkg::gf_xb(a3);
         inv_mix[12 - 4*c] = aes_pkg::gf_xb(a0) ^ aes_pkg::gf_xd(a1) ^
                             aes_pkg::gf_x9(a2) ^ aes_pkg::gf_xe(a3);
      end
   end

   assign state_out = last ? add_key : inv_mix;   // No InvMixColumns on the final round.

endmodule

// ==== aes_result.sv ====
`timescale 1ns/100ps

// Output stage. Holds the finished block and flags it for one cycle.
module aes_result (
   input  logic            eph1,
   input  logic            rst,
   input  logic            last,
   input  aes_pkg::block_t state_in,
   output logic            done,
   output aes_pkg::block_t block_out
);

   // The done strobe follows last by one edge. last is high for a single
   // cycle per block, so done is one pulse.
   always_ff @(posedge eph1) begin
      if (rst) begin
         done <= 1'b0;
      end else begin
         done <= last;
      end
   end

   // The result register only moves on the final round and then holds.
   always_ff @(posedge eph1) begin
      if (last) begin
         block_out <= state_in;              // Same edge that raises done.
      end
   end

endmodule

// ==== aes_core.sv ====
`timescale 1ns/100ps

// One AES direction that runs one round per clock.
module aes_core #(
   parameter bit DECRYPT = 1'b0              // 0 builds the encryptor and 1 the decryptor.
) (
   input  logic                eph1,
   input  logic                rst,
   input  logic                start,
   input  aes_pkg::block_t     block_in,
   input  aes_pkg::key_size_e  key_size,
   input  aes_pkg::key_sched_t key_words,
   output logic                done,
   output aes_pkg::block_t     block_out
);

   logic                first;
   logic                last;
   logic                busy;
   aes_pkg::round_key_t round_key;
   aes_pkg::round_key_t init_key;
   aes_pkg::block_t     state_r;             // Cipher state between rounds.
   aes_pkg::block_t     round_out;

   aes_round_ctrl #(
      .DECRYPT (DECRYPT)
   ) ctrl_i (
      .eph1      (eph1),
      .rst       (rst),
      .start     (start),
      .key_size  (key_size),
      .key_words (key_words),
      .first     (first),
      .last      (last),
      .busy      (busy),
      .round_key (round_key),
      .init_key  (init_key)
   );

   // ==========================================================
   // State register
   // ==========================================================
   // The start edge loads the whitened input. Each later edge of a run stores one round.
   always_ff @(posedge eph1) begin
      if (first) begin
         state_r <= block_in ^ init_key;
      end else if (busy) begin
         state_r <= round_out;
      end
   end

   generate
      if (DECRYPT) begin : g_dec
         aes_dec_round dec_round_i (
            .state_in  (state_r),
            .round_key (round_key),
            .last      (last),
            .state_out (round_out)
         );
      end else begin : g_enc
         aes_enc_round enc_round_i (
            .state_in  (state_r),
            .round_key (round_key),
            .last      (last),
            .state_out (round_out)
         );
      end
   endgenerate

   aes_result result_i (
      .eph1      (eph1),
      .rst       (rst),
      .last      (last),
      .state_in  (round_out),                // Final round output goes straight in.
      .done      (done),
      .block_out (block_out)
   );

endmodule

// ==== aes_build.sv ====
`timescale 1ns/100ps

// Top level. Encrypts a block, then decrypts the cipher text again.
module aes_build #(
   parameter aes_pkg::key_size_e DEFAULT_KEY_SIZE = aes_pkg::KEY_128
) (
   input  logic                eph1,
   input  logic                rst,
   input  logic                key_load,
   input  logic [1:0]          key_size,
   input  aes_pkg::key_sched_t key_words,
   input  logic                start,
   input  aes_pkg::block_t     plain_text,
   output logic                enc_done,
   output aes_pkg::block_t     cipher_text,
   output logic                dec_done,
   output aes_pkg::block_t     plain_out
);

   aes_pkg::key_size_e  key_size_r;
   aes_pkg::key_sched_t key_words_r;         // Pre-expanded schedule, key 0 first.

   // ==========================================================
   // Key store
   // ==========================================================
   always_ff @(posedge eph1) begin
      if (rst) begin
         key_size_r <= DEFAULT_KEY_SIZE;
      end else if (key_load) begin
         key_size_r <= aes_pkg::key_size_e'(key_size);   // Code 2'b11 is kept as is.
      end
   end

   always_ff @(posedge eph1) begin
      if (key_load) begin
         key_words_r <= key_words;
      end
   end

   // The encryptor's done strobe starts the decryptor on its own cipher text.
   aes_core #(.DECRYPT(1'b0)) enc_core_i (
      .eph1 (eph1), .rst (rst), .start (start), .block_in (plain_text),
      .key_size (key_size_r), .key_words (key_words_r),
      .done (enc_done), .block_out (cipher_text)
   );

   aes_core #(.DECRYPT(1'b1)) dec_core_i (
      .eph1 (eph1), .rst (rst), .start (enc_done), .block_in (cipher_text),
      .key_size (key_size_r), .key_words (key_words_r),
      .done (dec_done), .block_out (plain_out)
   );

endmodule

// ==== aes_checker.sv ====
`timescale 1ns/100ps

// Watches the DUT ports, predicts every block and compares the results.
module aes_checker (
   input  logic                eph1,
   input  logic                rst,
   input  logic                key_load,
   input  logic [1:0]          key_size,
   input  aes_pkg::key_sched_t key_words,
   input  logic                start,
   input  aes_pkg::block_t     plain_text,
   input  logic                enc_done,
   input  aes_pkg::block_t     cipher_text,
   input  logic                dec_done,
   input  aes_pkg::block_t     plain_out,
   output int                  error_count,
   output int                  block_count
);

   aes_pkg::key_sched_t keys;              // Model copy of the key store.
   int                  nr;                // Round count for the stored key size.
   bit                  enc_busy;          // A block is in the encryptor.
   bit                  dec_busy;
   int                  enc_edges;         // Edges seen since the start, the start edge is 1.
   int                  dec_edges;
   aes_pkg::block_t     enc_plain;         // Plain text of the block in the encryptor.
   aes_pkg::block_t     enc_expect;        // Predicted cipher text.
   aes_pkg::block_t     dec_expect;        // The round trip must give the plain text back.

   // 2'b00 runs 10 rounds, 2'b01 runs 12, and both other codes run 14.
   function automatic int rounds_for(input logic [1:0] code);
      case (code)
         2'b00:   return 10;
         2'b01:   return 12;
         default: return 14;
      endcase
   endfunction

   // ==========================================================
   // Reference AES encryption over the stored round keys
   // ==========================================================
   function automatic aes_pkg::block_t encrypt_model(
      input aes_pkg::block_t     pt,
      input aes_pkg::key_sched_t ks,
      input int                  rounds
   );
      aes_pkg::byte_t  s [4][4];          // State held as s[row][column].
      aes_pkg::byte_t  t [4][4];
      aes_pkg::block_t ct;
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            s[r][c] = pt[15 - 4*c - r] ^ ks[0][15 - 4*c - r];   // Key whitening.
         end
      end
      for (int rnd = 1; rnd <= rounds; rnd++) begin
         for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
               t[r][c] = aes_pkg::SBOX[s[r][(c + r) % 4]];   // SubBytes after ShiftRows.
            end
         end
         for (int c = 0; c < 4; c++) begin
            if (rnd == rounds) begin       // The final round has no MixColumns.
               for (int r = 0; r < 4; r++) begin
                  s[r][c] = t[r][c];
               end
            end else begin
               s[0][c] = aes_pkg::gf_x2(t[0][c]) ^ aes_pkg::gf_x3(t[1][c]) ^ t[2][c] ^ t[3][c];
               s[1][c] = t[0][c] ^ aes_pkg::gf_x2(t[1][c]) ^ aes_pkg::gf_x3(t[2][c]) ^ t[3][c];
               s[2][c] = t[0][c] ^ t[1][c] ^ aes_pkg::gf_x2(t[2][c]) ^ aes_pkg::gf_x3(t[3][c]);
               s[3][c] = aes_pkg::gf_x3(t[0][c]) ^ t[1][c] ^ t[2][c] ^ aes_pkg::gf_x2(t[3][c]);
            end
            for (int r = 0; r < 4; r++) begin
               s[r][c] = s[r][c] ^ ks[rnd][15 - 4*c - r];   // AddRoundKey.
            end
         end
      end
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            ct[15 - 4*c - r] = s[r][c];
         end
      end
      return ct;
   endfunction

   // ==========================================================
   // Port monitor
   // ==========================================================
   // Done strobes are handled before a start, so a start on the same edge is a new block.
   always @(posedge eph1) begin
      if (rst) begin
         enc_busy    = 1'b0;
         dec_busy    = 1'b0;
         nr          = 10;                 // The key store resets to a 128-bit key.
         error_count = 0;
         block_count = 0;
      end else begin
         if (enc_busy) begin
            enc_edges++;
         end
         if (dec_busy) begin
            dec_edges++;
         end
         if (enc_done !== 1'b0) begin
            if (!enc_busy) begin
               $display("Error: enc_done rose with no block in flight at %0t", $time);
               error_count++;
            end else begin
               if (enc_edges != nr + 2) begin
                  $display("Error: enc_done came %0d edges after start, expected %0d",
                           enc_edges, nr + 2);
                  error_count++;
               end
               if (cipher_text !== enc_expect) begin
                  $display("CHECK FAILED: cipher_text = %h, expected %h at %0t",
                           cipher_text, enc_expect, $time);
                  error_count++;
               end
               enc_busy   = 1'b0;
               dec_busy   = 1'b1;          // enc_done is the decryptor's start.
               dec_edges  = 1;
               dec_expect = enc_plain;
            end
         end else if (enc_busy && enc_edges > nr + 2) begin
            $display("Error: enc_done did not come %0d edges after start", nr + 2);
            error_count++;
            enc_busy = 1'b0;
         end
         if (dec_done !== 1'b0) begin
            if (!dec_busy) begin
               $display("Error: dec_done rose with no block in flight at %0t", $time);
               error_count++;
            end else begin
               if (dec_edges != nr + 2) begin
                  $display("Error: dec_done came %0d edges after enc_done, expected %0d",
                           dec_edges, nr + 2);
                  error_count++;
               end
               if (plain_out !== dec_expect) begin
                  $display("CHECK FAILED: plain_out = %h, expected %h at %0t",
                           plain_out, dec_expect, $time);
                  error_count++;
               end
               dec_busy = 1'b0;
               block_count++;
            end
         end else if (dec_busy && dec_edges > nr + 2) begin
            $display("Error: dec_done did not come %0d edges after enc_done", nr + 2);
            error_count++;
            dec_busy = 1'b0;
         end
         if (key_load) begin
            keys = key_words;
            nr   = rounds_for(key_size);
         end
         if (start) begin                  // A start while busy drops the old block.
            enc_busy   = 1'b1;
            enc_edges  = 1;
            enc_plain  = plain_text;
            enc_expect = encrypt_model(plain_text, keys, nr);
         end
      end
   end

endmodule

// ==== tb_aes_build.sv ====
`timescale 1ns/100ps

module tb_aes_build;

   localparam int DRIVE_DELAY  = 2;        // Inputs change this long after the rising edge.
   localparam int DONE_TIMEOUT = 40;       // Cycles allowed for a full encrypt and decrypt.

   logic                eph1;
   logic                rst;
   logic                key_load;
   logic [1:0]          key_size;
   aes_pkg::key_sched_t key_words;
   logic                start;
   aes_pkg::block_t     plain_text;
   logic                enc_done;
   aes_pkg::block_t     cipher_text;
   logic                dec_done;
   aes_pkg::block_t     plain_out;

   integer      seed;
   logic [31:0] rnd;
   int          timeouts;
   int          check_errors;
   int          blocks_checked;

   aes_build #(
      .DEFAULT_KEY_SIZE (aes_pkg::KEY_128)
   ) dut_i (
      .eph1        (eph1),
      .rst         (rst),
      .key_load    (key_load),
      .key_size    (key_size),
      .key_words   (key_words),
      .start       (start),
      .plain_text  (plain_text),
      .enc_done    (enc_done),
      .cipher_text (cipher_text),
      .dec_done    (dec_done),
      .plain_out   (plain_out)
   );

   aes_checker checker_i (
      .eph1 (eph1), .rst (rst), .key_load (key_load), .key_size (key_size),
      .key_words (key_words), .start (start), .plain_text (plain_text),
      .enc_done (enc_done), .cipher_text (cipher_text), .dec_done (dec_done),
      .plain_out (plain_out), .error_count (check_errors), .block_count (blocks_checked)
   );

   initial begin
      eph1 = 1'b0;
   end
   always #10 eph1 = ~eph1;                // 20 ns period.

   // ==========================================================
   // Stimulus tasks
   // ==========================================================
   // Every task starts and ends DRIVE_DELAY after a rising edge.
   task automatic step();
      @(posedge eph1);
      #DRIVE_DELAY;
   endtask

   function automatic aes_pkg::block_t random_block();
      aes_pkg::block_t blk;
      for (int w = 0; w < 4; w++) begin
         blk[4*w +: 4] = $random(seed);    // Four random bytes at a time.
      end
      return blk;
   endfunction

   task automatic load_keys(input logic [1:0] size);
      key_load = 1'b1;
      key_size = size;
      for (int k = 0; k < aes_pkg::NUM_ROUND_KEYS; k++) begin
         key_words[k] = random_block();    // Any schedule works for a round trip.
      end
      step();
      key_load = 1'b0;
   endtask

   task automatic send_block();
      start      = 1'b1;
      plain_text = random_block();
      step();                              // The start edge.
      start      = 1'b0;
   endtask

   task automatic wait_dec_done();
      int cycles;
      bit seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < DONE_TIMEOUT) begin
         step();
         cycles++;
         seen = (dec_done === 1'b1);
      end
      if (!seen) begin
         $display("Timeout: dec_done did not rise within %0d cycles at %0t",
                  DONE_TIMEOUT, $time);
         timeouts++;
      end
   endtask

   // The first block is dropped by a second start gap cycles after its start edge.
   task automatic restart_block(input int gap);
      send_block();
      repeat (gap) step();
      send_block();
      wait_dec_done();
   endtask

   // ==========================================================
   // Test sequence
   // ==========================================================
   initial begin
      seed       = 32'hab73_3b5a;
      timeouts   = 0;
      rst        = 1'b1;
      key_load   = 1'b0;
      key_size   = 2'b00;
      key_words  = '0;
      start      = 1'b0;
      plain_text = '0;
      repeat (5) @(posedge eph1);          // Reset spans five edges.
      #DRIVE_DELAY;
      rst = 1'b0;
      repeat (5) step();                   // Idle, so no done may appear.
      // All four key-size codes, 2'b11 included.
      for (int code = 0; code < 4 && timeouts == 0; code++) begin
         load_keys(2'(code));
         for (int n = 0; n < 4 && timeouts == 0; n++) begin
            send_block();
            wait_dec_done();
         end
      end
      // Fresh schedule and random key size for every block.
      for (int n = 0; n < 12 && timeouts == 0; n++) begin
         rnd = $random(seed);
         load_keys(rnd[1:0]);
         send_block();
         wait_dec_done();
      end
      // Restart early in a run, then on the edge that would finish the old block.
      for (int code = 0; code < 4 && timeouts == 0; code++) begin
         load_keys(2'(code));
         restart_block(2);
         restart_block((code == 0) ? 9 : (code == 1) ? 11 : 13);
      end
      repeat (3) step();
      $display("Check errors: %0d, timeouts: %0d, blocks round-tripped: %0d",
               check_errors, timeouts, blocks_checked);
      if (check_errors == 0 && timeouts == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// ==== sim.f ====
aes_pkg.sv
aes_round_ctrl.sv
aes_enc_round.sv
aes_dec_round.sv
aes_result.sv
aes_core.sv
aes_build.sv
aes_checker.sv
tb_aes_build.sv

// ==== Makefile ====
.PHONY: sim clean

# The simulation passes only when the pass message shows up in the output.
sim:
	verilator --binary --timing -f sim.f --top-module tb_aes_build -o tb_aes_build
	./obj_dir/tb_aes_build | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir
